// ==== Bender.yml ====
package:
  name: l2_cache

sources:
  # Design, in compile order
  - files:
      - source/l2_cache_pkg.sv
      - source/l2_request_router.sv
      - source/l2_cache_bank.sv
      - source/l2_cache_response.sv
      - source/l2_cache.sv

  # Testbench and bound assertions
  - target: test
    files:
      - testbench/l2_cache_sva.sv
      - testbench/l2_cache_tb.sv

// ==== sim.f ====
source/l2_cache_pkg.sv
source/l2_request_router.sv
source/l2_cache_bank.sv
source/l2_cache_response.sv
source/l2_cache.sv
testbench/l2_cache_sva.sv
testbench/l2_cache_tb.sv

// ==== source/l2_cache.sv ====
`timescale 1ns/1ps

module l2_cache (
	input  logic clk,
	input  logic reset,
	input  logic pci_valid,
	output logic pci_ready,
	input  l2_cache_pkg::unit_t pci_unit,
	input  l2_cache_pkg::strand_t pci_strand,
	input  l2_cache_pkg::pci_op_t pci_op,
	input  l2_cache_pkg::way_t pci_way,
	input  l2_cache_pkg::line_addr_t pci_addr,
	input  l2_cache_pkg::byte_mask_t pci_mask,
	input  l2_cache_pkg::line_data_t pci_data,
	output logic cpi_valid,
	output logic cpi_status,
	output l2_cache_pkg::unit_t cpi_unit,
	output l2_cache_pkg::strand_t cpi_strand,
	output l2_cache_pkg::cpi_op_t cpi_op,
	output l2_cache_pkg::way_t cpi_way,
	output l2_cache_pkg::line_data_t cpi_data
);

	// Router to banks
	wire [l2_cache_pkg::num_banks-1:0] bank_valid;
	wire [l2_cache_pkg::num_banks-1:0] bank_ready;
	l2_cache_pkg::unit_t req_unit;
	l2_cache_pkg::strand_t req_strand;
	l2_cache_pkg::pci_op_t req_op;
	l2_cache_pkg::way_t req_way;
	l2_cache_pkg::line_addr_t req_addr;
	l2_cache_pkg::byte_mask_t req_mask;
	l2_cache_pkg::line_data_t req_data;

	// Banks to response stage, one slot per bank
	wire [l2_cache_pkg::num_banks-1:0] bank_rsp_valid;
	wire [l2_cache_pkg::num_banks-1:0] bank_rsp_ready;
	wire l2_cache_pkg::unit_t [l2_cache_pkg::num_banks-1:0] bank_rsp_unit;
	wire l2_cache_pkg::strand_t [l2_cache_pkg::num_banks-1:0] bank_rsp_strand;
	wire l2_cache_pkg::pci_op_t [l2_cache_pkg::num_banks-1:0] bank_rsp_op;
	wire l2_cache_pkg::way_t [l2_cache_pkg::num_banks-1:0] bank_rsp_way;
	wire l2_cache_pkg::line_data_t [l2_cache_pkg::num_banks-1:0] bank_rsp_data;
	wire [l2_cache_pkg::num_banks-1:0] bank_rsp_sync_ok;

	l2_request_router i_router (
		.clk(clk), .reset(reset),
		.pci_valid(pci_valid), .pci_unit(pci_unit), .pci_strand(pci_strand),
		.pci_op(pci_op), .pci_way(pci_way), .pci_addr(pci_addr),
		.pci_mask(pci_mask), .pci_data(pci_data), .bank_ready(bank_ready),
		.pci_ready(pci_ready), .bank_valid(bank_valid),
		.req_unit(req_unit), .req_strand(req_strand), .req_op(req_op),
		.req_way(req_way), .req_addr(req_addr), .req_mask(req_mask),
		.req_data(req_data)
	);

	for (genvar i = 0; i < l2_cache_pkg::num_banks; i++)
	begin : g_bank
		l2_cache_bank i_bank (
			.clk(clk), .reset(reset),
			.req_valid(bank_valid[i]), .req_unit(req_unit), .req_strand(req_strand),
			.req_op(req_op), .req_way(req_way), .req_addr(req_addr),
			.req_mask(req_mask), .req_data(req_data), .rsp_ready(bank_rsp_ready[i]),
			.req_ready(bank_ready[i]), .rsp_valid(bank_rsp_valid[i]),
			.rsp_unit(bank_rsp_unit[i]), .rsp_strand(bank_rsp_strand[i]),
			.rsp_op(bank_rsp_op[i]), .rsp_way(bank_rsp_way[i]),
			.rsp_data(bank_rsp_data[i]), .rsp_sync_ok(bank_rsp_sync_ok[i])
		);
	end

	l2_cache_response i_response (
		.clk(clk), .reset(reset),
		.bank_rsp_valid(bank_rsp_valid), .bank_rsp_unit(bank_rsp_unit),
		.bank_rsp_strand(bank_rsp_strand), .bank_rsp_op(bank_rsp_op),
		.bank_rsp_way(bank_rsp_way), .bank_rsp_data(bank_rsp_data),
		.bank_rsp_sync_ok(bank_rsp_sync_ok), .bank_rsp_ready(bank_rsp_ready),
		.cpi_valid(cpi_valid), .cpi_status(cpi_status), .cpi_unit(cpi_unit),
		.cpi_strand(cpi_strand), .cpi_op(cpi_op), .cpi_way(cpi_way),
		.cpi_data(cpi_data)
	);

endmodule

// ==== source/l2_cache_bank.sv ====
`timescale 1ns/1ps

module l2_cache_bank (
	input  logic clk,
	input  logic reset,
	input  logic req_valid,
	input  l2_cache_pkg::unit_t req_unit,
	input  l2_cache_pkg::strand_t req_strand,
	input  l2_cache_pkg::pci_op_t req_op,
	input  l2_cache_pkg::way_t req_way,
	input  l2_cache_pkg::line_addr_t req_addr,
	input  l2_cache_pkg::byte_mask_t req_mask,
	input  l2_cache_pkg::line_data_t req_data,
	input  logic rsp_ready,
	output logic req_ready,
	output logic rsp_valid,
	output l2_cache_pkg::unit_t rsp_unit,
	output l2_cache_pkg::strand_t rsp_strand,
	output l2_cache_pkg::pci_op_t rsp_op,
	output l2_cache_pkg::way_t rsp_way,
	output l2_cache_pkg::line_data_t rsp_data,
	output logic rsp_sync_ok
);

	l2_cache_pkg::bank_state_t state;

	// Request in flight, one per bank
	l2_cache_pkg::unit_t cur_unit;
	l2_cache_pkg::strand_t cur_strand;
	l2_cache_pkg::pci_op_t cur_op;
	l2_cache_pkg::way_t cur_way;
	l2_cache_pkg::line_addr_t cur_addr;
	l2_cache_pkg::byte_mask_t cur_mask;
	l2_cache_pkg::line_data_t cur_data;

	// Direct-mapped cache and the backing slice behind it
	l2_cache_pkg::line_data_t data_arr [l2_cache_pkg::sets_per_bank];
	l2_cache_pkg::tag_t tag_arr [l2_cache_pkg::sets_per_bank];
	logic [l2_cache_pkg::sets_per_bank-1:0] line_valid;
	l2_cache_pkg::line_data_t backing [l2_cache_pkg::lines_per_bank];

	// Sync reservations indexed by {unit, strand}
	logic [l2_cache_pkg::resv_entries-1:0] resv_valid;
	l2_cache_pkg::line_addr_t resv_addr [l2_cache_pkg::resv_entries];

	logic [$clog2(l2_cache_pkg::fill_cycles)-1:0] fill_count;

	l2_cache_pkg::set_idx_t set_idx;
	l2_cache_pkg::tag_t cur_tag;
	l2_cache_pkg::line_idx_t line_idx;
	logic [$clog2(l2_cache_pkg::resv_entries)-1:0] resv_id;
	logic hit;
	logic sync_ok;
	logic do_store;
	logic do_exec;
	l2_cache_pkg::line_data_t base_line;
	l2_cache_pkg::line_data_t new_line;

	assign set_idx = cur_addr[l2_cache_pkg::bank_bits +: l2_cache_pkg::set_bits];
	assign cur_tag = cur_addr[l2_cache_pkg::bank_bits + l2_cache_pkg::set_bits +:
		l2_cache_pkg::tag_bits];
	assign line_idx = cur_addr[l2_cache_pkg::bank_bits +:
		l2_cache_pkg::set_bits + l2_cache_pkg::tag_bits];
	assign resv_id = {cur_unit, cur_strand};

	assign hit = line_valid[set_idx] && tag_arr[set_idx] == cur_tag;

	// Store-sync only goes through while its own reservation still holds
	assign sync_ok = cur_op == l2_cache_pkg::pci_store_sync && resv_valid[resv_id]
		&& resv_addr[resv_id] == cur_addr;
	assign do_store = cur_op == l2_cache_pkg::pci_store || sync_ok;

	// The op executes at the end of lookup on a hit, or on the last fill cycle
	assign do_exec = (state == l2_cache_pkg::st_lookup && hit)
		|| (state == l2_cache_pkg::st_fill
		&& int'(fill_count) == l2_cache_pkg::fill_cycles - 1);

	assign base_line = (state == l2_cache_pkg::st_lookup) ? data_arr[set_idx]
		: backing[line_idx];

	// Byte merge of the store data
	always_comb
	begin
		new_line = base_line;
		if (do_store)
		begin
			for (int b = 0; b < l2_cache_pkg::line_bytes; b++)
			begin
				if (cur_mask[b])
					new_line[b*8 +: 8] = cur_data[b*8 +: 8];
			end
		end
	end

	assign req_ready = state == l2_cache_pkg::st_idle;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= l2_cache_pkg::st_idle;
			rsp_valid <= 1'b0;
			fill_count <= '0;
		end
		else
		begin
			fill_count <= (state == l2_cache_pkg::st_fill) ? fill_count + 1'b1 : '0;
			case (state)
				l2_cache_pkg::st_idle:
					if (req_valid)
						state <= l2_cache_pkg::st_lookup;
				l2_cache_pkg::st_lookup:
					state <= hit ? l2_cache_pkg::st_respond : l2_cache_pkg::st_fill;
				l2_cache_pkg::st_fill:
					if (do_exec)
						state <= l2_cache_pkg::st_respond;
				l2_cache_pkg::st_respond:
					// First cycle reads back the updated line, then hold until granted
					if (!rsp_valid)
						rsp_valid <= 1'b1;
					else if (rsp_ready)
					begin
						rsp_valid <= 1'b0;
						state <= l2_cache_pkg::st_idle;
					end
				default:
					state <= l2_cache_pkg::st_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			line_valid <= '0;
			resv_valid <= '0;
		end
		else if (do_exec)
		begin
			line_valid[set_idx] <= 1'b1;
			// Any write to a reserved line breaks every reservation on it
			for (int r = 0; r < l2_cache_pkg::resv_entries; r++)
			begin
				if (do_store && resv_addr[r] == cur_addr)
					resv_valid[r] <= 1'b0;
			end
			if (cur_op == l2_cache_pkg::pci_load_sync)
				resv_valid[resv_id] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == l2_cache_pkg::st_idle && req_valid)
		begin
			cur_unit <= req_unit;
			cur_strand <= req_strand;
			cur_op <= req_op;
			cur_way <= req_way;
			cur_addr <= req_addr;
			cur_mask <= req_mask;
			cur_data <= req_data;
		end
		if (do_exec)
		begin
			data_arr[set_idx] <= new_line;
			tag_arr[set_idx] <= cur_tag;
			// Write-through keeps the backing slice current
			if (do_store)
				backing[line_idx] <= new_line;
			if (cur_op == l2_cache_pkg::pci_load_sync)
				resv_addr[resv_id] <= cur_addr;
			rsp_sync_ok <= sync_ok;
		end
		if (state == l2_cache_pkg::st_respond && !rsp_valid)
			rsp_data <= data_arr[set_idx];
	end

	assign rsp_unit = cur_unit;
	assign rsp_strand = cur_strand;
	assign rsp_op = cur_op;
	assign rsp_way = cur_way;

endmodule

// ==== source/l2_cache_pkg.sv ====
package l2_cache_pkg;

	// Bank geometry
	localparam int num_banks = 4;
	localparam int bank_bits = 2;
	localparam int sets_per_bank = 4;
	localparam int set_bits = 2;
	localparam int tag_bits = 2;
	localparam int lines_per_bank = 16;

	// Cycles spent in the fill state on a miss
	localparam int fill_cycles = 4;

	localparam int line_addr_bits = bank_bits + set_bits + tag_bits;
	localparam int line_bytes = 64;

	// Line address is {tag, set, bank}
	typedef logic [line_addr_bits-1:0] line_addr_t;
	typedef logic [line_bytes*8-1:0] line_data_t;
	typedef logic [line_bytes-1:0] byte_mask_t;

	// Requester identity and the L1 way it asked for
	typedef logic [1:0] unit_t;
	typedef logic [1:0] strand_t;
	typedef logic [1:0] way_t;

	typedef logic [bank_bits-1:0] bank_idx_t;
	typedef logic [set_bits-1:0] set_idx_t;
	typedef logic [tag_bits-1:0] tag_t;

	// Backing line index inside one bank, {tag, set}
	typedef logic [$clog2(lines_per_bank)-1:0] line_idx_t;

	// One reservation slot per unit and strand
	localparam int resv_entries = 2 ** ($bits(unit_t) + $bits(strand_t));

	typedef enum logic [2:0]
	{
		pci_load = 3'd0,
		pci_store = 3'd1,
		pci_flush = 3'd2,
		pci_invalidate = 3'd3,
		pci_load_sync = 3'd4,
		pci_store_sync = 3'd5
	} pci_op_t;

	typedef enum logic [1:0]
	{
		cpi_none = 2'd0,
		cpi_load_ack = 2'd1,
		cpi_store_ack = 2'd2
	} cpi_op_t;

	typedef enum logic [1:0]
	{
		st_idle,
		st_lookup,
		st_fill,
		st_respond
	} bank_state_t;

endpackage

// ==== source/l2_cache_response.sv ====
`timescale 1ns/1ps

module l2_cache_response (
	input  logic clk,
	input  logic reset,
	input  logic [l2_cache_pkg::num_banks-1:0] bank_rsp_valid,
	input  l2_cache_pkg::unit_t [l2_cache_pkg::num_banks-1:0] bank_rsp_unit,
	input  l2_cache_pkg::strand_t [l2_cache_pkg::num_banks-1:0] bank_rsp_strand,
	input  l2_cache_pkg::pci_op_t [l2_cache_pkg::num_banks-1:0] bank_rsp_op,
	input  l2_cache_pkg::way_t [l2_cache_pkg::num_banks-1:0] bank_rsp_way,
	input  l2_cache_pkg::line_data_t [l2_cache_pkg::num_banks-1:0] bank_rsp_data,
	input  logic [l2_cache_pkg::num_banks-1:0] bank_rsp_sync_ok,
	output logic [l2_cache_pkg::num_banks-1:0] bank_rsp_ready,
	output logic cpi_valid,
	output logic cpi_status,
	output l2_cache_pkg::unit_t cpi_unit,
	output l2_cache_pkg::strand_t cpi_strand,
	output l2_cache_pkg::cpi_op_t cpi_op,
	output l2_cache_pkg::way_t cpi_way,
	output l2_cache_pkg::line_data_t cpi_data
);

	l2_cache_pkg::bank_idx_t last_grant;
	l2_cache_pkg::bank_idx_t grant_idx;
	l2_cache_pkg::bank_idx_t cand;
	logic grant_any;

	function automatic l2_cache_pkg::cpi_op_t ack_op(input l2_cache_pkg::pci_op_t op);
		case (op)
			l2_cache_pkg::pci_load,
			l2_cache_pkg::pci_load_sync: return l2_cache_pkg::cpi_load_ack;
			l2_cache_pkg::pci_store,
			l2_cache_pkg::pci_store_sync: return l2_cache_pkg::cpi_store_ack;
			default: return l2_cache_pkg::cpi_none;
		endcase
	endfunction

	// Search starts one past the last winner
	always_comb
	begin
		grant_idx = '0;
		grant_any = 1'b0;
		cand = '0;
		for (int i = 0; i < l2_cache_pkg::num_banks; i++)
		begin
			cand = l2_cache_pkg::bank_idx_t'(last_grant + 1 + i);
			if (!grant_any && bank_rsp_valid[cand])
			begin
				grant_idx = cand;
				grant_any = 1'b1;
			end
		end
	end

	always_comb
	begin
		bank_rsp_ready = '0;
		if (grant_any)
			bank_rsp_ready[grant_idx] = 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			cpi_valid <= 1'b0;
			last_grant <= l2_cache_pkg::bank_idx_t'(l2_cache_pkg::num_banks - 1);
		end
		else
		begin
			cpi_valid <= grant_any;
			if (grant_any)
				last_grant <= grant_idx;
		end
	end

	always_ff @(posedge clk)
	begin
		if (grant_any)
		begin
			// Status only means something for store-sync
			cpi_status <= bank_rsp_op[grant_idx] == l2_cache_pkg::pci_store_sync
				&& bank_rsp_sync_ok[grant_idx];
			cpi_unit <= bank_rsp_unit[grant_idx];
			cpi_strand <= bank_rsp_strand[grant_idx];
			cpi_op <= ack_op(bank_rsp_op[grant_idx]);
			cpi_way <= bank_rsp_way[grant_idx];
			cpi_data <= bank_rsp_data[grant_idx];
		end
	end

endmodule

// ==== source/l2_request_router.sv ====
`timescale 1ns/1ps

module l2_request_router (
	input  logic clk,
	input  logic reset,
	input  logic pci_valid,
	input  l2_cache_pkg::unit_t pci_unit,
	input  l2_cache_pkg::strand_t pci_strand,
	input  l2_cache_pkg::pci_op_t pci_op,
	input  l2_cache_pkg::way_t pci_way,
	input  l2_cache_pkg::line_addr_t pci_addr,
	input  l2_cache_pkg::byte_mask_t pci_mask,
	input  l2_cache_pkg::line_data_t pci_data,
	input  logic [l2_cache_pkg::num_banks-1:0] bank_ready,
	output logic pci_ready,
	output logic [l2_cache_pkg::num_banks-1:0] bank_valid,
	output l2_cache_pkg::unit_t req_unit,
	output l2_cache_pkg::strand_t req_strand,
	output l2_cache_pkg::pci_op_t req_op,
	output l2_cache_pkg::way_t req_way,
	output l2_cache_pkg::line_addr_t req_addr,
	output l2_cache_pkg::byte_mask_t req_mask,
	output l2_cache_pkg::line_data_t req_data
);

	l2_cache_pkg::bank_idx_t bank_sel;
	logic forward;
	logic accept_en;

	// PCI side stays closed until the first cycle out of reset
	always_ff @(posedge clk)
	begin
		if (reset)
			accept_en <= 1'b0;
		else
			accept_en <= 1'b1;
	end

	// Low line address bits pick the owning bank
	assign bank_sel = pci_addr[l2_cache_pkg::bank_bits-1:0];

	// Flush and invalidate are consumed here and never reach a bank
	always_comb
	begin
		case (pci_op)
			l2_cache_pkg::pci_load,
			l2_cache_pkg::pci_store,
			l2_cache_pkg::pci_load_sync,
			l2_cache_pkg::pci_store_sync: forward = 1'b1;
			default: forward = 1'b0;
		endcase
	end

	assign pci_ready = accept_en && bank_ready[bank_sel];

	always_comb
	begin
		bank_valid = '0;
		if (accept_en && pci_valid && forward)
			bank_valid[bank_sel] = 1'b1;
	end

	// Payload is shared, only the addressed bank sees a valid
	assign req_unit = pci_unit;
	assign req_strand = pci_strand;
	assign req_op = pci_op;
	assign req_way = pci_way;
	assign req_addr = pci_addr;
	assign req_mask = pci_mask;
	assign req_data = pci_data;

endmodule

// ==== testbench/l2_cache_sva.sv ====
`timescale 1ns/1ps

module l2_cache_sva (
	input logic clk,
	input logic reset,
	input logic pci_valid,
	input logic pci_ready,
	input l2_cache_pkg::unit_t pci_unit,
	input l2_cache_pkg::strand_t pci_strand,
	input l2_cache_pkg::pci_op_t pci_op,
	input l2_cache_pkg::way_t pci_way,
	input l2_cache_pkg::line_addr_t pci_addr,
	input l2_cache_pkg::byte_mask_t pci_mask,
	input l2_cache_pkg::line_data_t pci_data,
	input logic cpi_valid,
	input l2_cache_pkg::cpi_op_t cpi_op
);

	// A waiting request keeps valid and its payload until the transfer
	property pci_request_held;
		@(posedge clk) disable iff (reset)
		pci_valid && !pci_ready |=> pci_valid
			&& $stable({pci_unit, pci_strand, pci_op, pci_way, pci_addr, pci_mask, pci_data});
	endproperty

	// Every reset cycle clears the CPI valid
	property cpi_quiet_in_reset;
		@(posedge clk) reset |=> !cpi_valid;
	endproperty

	property cpi_op_present;
		@(posedge clk) disable iff (reset)
		cpi_valid |-> cpi_op != l2_cache_pkg::cpi_none;
	endproperty

	assert property (pci_request_held)
	else
		$error("PCI request changed or dropped before it was accepted");

	assert property (cpi_quiet_in_reset)
	else
		$error("cpi_valid high while reset is asserted");

	assert property (cpi_op_present)
	else
		$error("cpi_valid high with cpi_op set to none");

endmodule

// ==== testbench/l2_cache_tb.sv ====
`timescale 1ns/1ps

module l2_cache_tb;

	logic clk;
	logic reset;
	logic pci_valid;
	logic pci_ready;
	l2_cache_pkg::unit_t pci_unit;
	l2_cache_pkg::strand_t pci_strand;
	l2_cache_pkg::pci_op_t pci_op;
	l2_cache_pkg::way_t pci_way;
	l2_cache_pkg::line_addr_t pci_addr;
	l2_cache_pkg::byte_mask_t pci_mask;
	l2_cache_pkg::line_data_t pci_data;
	logic cpi_valid;
	logic cpi_status;
	l2_cache_pkg::unit_t cpi_unit;
	l2_cache_pkg::strand_t cpi_strand;
	l2_cache_pkg::cpi_op_t cpi_op;
	l2_cache_pkg::way_t cpi_way;
	l2_cache_pkg::line_data_t cpi_data;

	// Expected contents of every line address
	l2_cache_pkg::line_data_t model [2 ** l2_cache_pkg::line_addr_bits];

	// Responses seen on CPI, oldest first
	l2_cache_pkg::unit_t got_unit_q [$];
	l2_cache_pkg::strand_t got_strand_q [$];
	l2_cache_pkg::cpi_op_t got_op_q [$];
	l2_cache_pkg::way_t got_way_q [$];
	l2_cache_pkg::line_data_t got_data_q [$];
	logic got_status_q [$];

	int max_wait_cycles = 100;
	integer seed = 32'hc3c2;
	int data_errors = 0;
	int op_errors = 0;
	int id_errors = 0;
	int way_errors = 0;
	int status_errors = 0;
	int protocol_errors = 0;

	l2_cache i_dut (
		.clk(clk), .reset(reset),
		.pci_valid(pci_valid), .pci_ready(pci_ready), .pci_unit(pci_unit),
		.pci_strand(pci_strand), .pci_op(pci_op), .pci_way(pci_way),
		.pci_addr(pci_addr), .pci_mask(pci_mask), .pci_data(pci_data),
		.cpi_valid(cpi_valid), .cpi_status(cpi_status), .cpi_unit(cpi_unit),
		.cpi_strand(cpi_strand), .cpi_op(cpi_op), .cpi_way(cpi_way),
		.cpi_data(cpi_data)
	);

	bind l2_cache l2_cache_sva i_sva (
		.clk(clk), .reset(reset),
		.pci_valid(pci_valid), .pci_ready(pci_ready), .pci_unit(pci_unit),
		.pci_strand(pci_strand), .pci_op(pci_op), .pci_way(pci_way),
		.pci_addr(pci_addr), .pci_mask(pci_mask), .pci_data(pci_data),
		.cpi_valid(cpi_valid), .cpi_op(cpi_op)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	// CPI outputs are sampled mid-cycle, away from the driving edge
	always @(negedge clk)
	begin
		if (!reset && cpi_valid)
		begin
			got_unit_q.push_back(cpi_unit);
			got_strand_q.push_back(cpi_strand);
			got_op_q.push_back(cpi_op);
			got_way_q.push_back(cpi_way);
			got_data_q.push_back(cpi_data);
			got_status_q.push_back(cpi_status);
		end
	end

	function automatic l2_cache_pkg::line_data_t random_line();
		l2_cache_pkg::line_data_t line;
		for (int w = 0; w < $bits(l2_cache_pkg::line_data_t) / 32; w++)
			line[w*32 +: 32] = $random(seed);
		return line;
	endfunction

	// Always partial: byte 0 written, byte 63 kept
	function automatic l2_cache_pkg::byte_mask_t random_mask();
		l2_cache_pkg::byte_mask_t mask;
		mask = {$random(seed), $random(seed)};
		mask[0] = 1'b1;
		mask[$bits(l2_cache_pkg::byte_mask_t) - 1] = 1'b0;
		return mask;
	endfunction

	function automatic l2_cache_pkg::line_data_t merge_line(
		input l2_cache_pkg::line_data_t old_line,
		input l2_cache_pkg::line_data_t new_bytes,
		input l2_cache_pkg::byte_mask_t mask);
		l2_cache_pkg::line_data_t result;
		result = old_line;
		for (int b = 0; b < $bits(l2_cache_pkg::byte_mask_t); b++)
		begin
			if (mask[b])
				result[b*8 +: 8] = new_bytes[b*8 +: 8];
		end
		return result;
	endfunction

	task automatic finish_run();
		int total;
		total = data_errors + op_errors + id_errors + way_errors + status_errors
			+ protocol_errors;
		$display("errors: data %0d, op %0d, id %0d, way %0d, status %0d, protocol %0d",
			data_errors, op_errors, id_errors, way_errors, status_errors, protocol_errors);
		if (total == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	endtask

	task automatic compare_data(input string name, input l2_cache_pkg::line_data_t got,
		input l2_cache_pkg::line_data_t exp);
		if (got !== exp)
		begin
			data_errors++;
			$display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic compare_op(input string name, input l2_cache_pkg::cpi_op_t got,
		input l2_cache_pkg::cpi_op_t exp);
		if (got !== exp)
		begin
			op_errors++;
			$display("FAILED %0t %s got %0d (%s) expected %0d (%s)", $time, name,
				got, got.name(), exp, exp.name());
		end
	endtask

	task automatic compare_id(input string name, input l2_cache_pkg::unit_t got_unit,
		input l2_cache_pkg::strand_t got_strand, input l2_cache_pkg::unit_t exp_unit,
		input l2_cache_pkg::strand_t exp_strand);
		if (got_unit !== exp_unit || got_strand !== exp_strand)
		begin
			id_errors++;
			$display("FAILED %0t %s got unit %0d strand %0d expected unit %0d strand %0d",
				$time, name, got_unit, got_strand, exp_unit, exp_strand);
		end
	endtask

	task automatic compare_way(input string name, input l2_cache_pkg::way_t got,
		input l2_cache_pkg::way_t exp);
		if (got !== exp)
		begin
			way_errors++;
			$display("FAILED %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic compare_status(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			status_errors++;
			$display("FAILED %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// Starts at a rising edge and returns at the edge of the transfer
	task automatic send_request(input l2_cache_pkg::unit_t unit,
		input l2_cache_pkg::strand_t strand, input l2_cache_pkg::pci_op_t op,
		input l2_cache_pkg::way_t way, input l2_cache_pkg::line_addr_t addr,
		input l2_cache_pkg::byte_mask_t mask, input l2_cache_pkg::line_data_t data);
		int waited;
		waited = 0;
		pci_valid <= 1'b1;
		pci_unit <= unit;
		pci_strand <= strand;
		pci_op <= op;
		pci_way <= way;
		pci_addr <= addr;
		pci_mask <= mask;
		pci_data <= data;
		@(negedge clk);
		while (!pci_ready && waited < max_wait_cycles)
		begin
			waited++;
			@(negedge clk);
		end
		if (!pci_ready)
		begin
			protocol_errors++;
			$display("Request to line %0d was not accepted within %0d cycles", addr,
				max_wait_cycles);
			finish_run();
		end
		else
			@(posedge clk);
	endtask

	task automatic release_bus();
		pci_valid <= 1'b0;
	endtask

	task automatic wait_response(output l2_cache_pkg::unit_t unit,
		output l2_cache_pkg::strand_t strand, output l2_cache_pkg::cpi_op_t op,
		output l2_cache_pkg::way_t way, output l2_cache_pkg::line_data_t data,
		output logic status);
		int waited;
		waited = 0;
		while (got_unit_q.size() == 0 && waited < max_wait_cycles)
		begin
			waited++;
			@(posedge clk);
		end
		if (got_unit_q.size() == 0)
		begin
			protocol_errors++;
			$display("No CPI response arrived within %0d cycles", max_wait_cycles);
			finish_run();
		end
		else
		begin
			unit = got_unit_q.pop_front();
			strand = got_strand_q.pop_front();
			op = got_op_q.pop_front();
			way = got_way_q.pop_front();
			data = got_data_q.pop_front();
			status = got_status_q.pop_front();
		end
	endtask

	// One request, one response, every field checked
	task automatic issue_and_check(input l2_cache_pkg::unit_t unit,
		input l2_cache_pkg::strand_t strand, input l2_cache_pkg::pci_op_t op,
		input l2_cache_pkg::way_t way, input l2_cache_pkg::line_addr_t addr,
		input l2_cache_pkg::byte_mask_t mask, input l2_cache_pkg::line_data_t data,
		input l2_cache_pkg::cpi_op_t exp_op, input l2_cache_pkg::line_data_t exp_data,
		input logic exp_status);
		l2_cache_pkg::unit_t r_unit;
		l2_cache_pkg::strand_t r_strand;
		l2_cache_pkg::cpi_op_t r_op;
		l2_cache_pkg::way_t r_way;
		l2_cache_pkg::line_data_t r_data;
		logic r_status;
		send_request(unit, strand, op, way, addr, mask, data);
		release_bus();
		wait_response(r_unit, r_strand, r_op, r_way, r_data, r_status);
		compare_op("cpi_op", r_op, exp_op);
		compare_id("cpi_unit/cpi_strand", r_unit, r_strand, unit, strand);
		compare_way("cpi_way", r_way, way);
		compare_data("cpi_data", r_data, exp_data);
		compare_status("cpi_status", r_status, exp_status);
	endtask

	task automatic do_load(input l2_cache_pkg::pci_op_t op, input l2_cache_pkg::unit_t unit,
		input l2_cache_pkg::strand_t strand, input l2_cache_pkg::way_t way,
		input l2_cache_pkg::line_addr_t addr);
		issue_and_check(unit, strand, op, way, addr, '0, '0, l2_cache_pkg::cpi_load_ack,
			model[addr], 1'b0);
	endtask

	// A store that is expected to fail leaves the model as it is
	task automatic do_store(input l2_cache_pkg::pci_op_t op, input l2_cache_pkg::unit_t unit,
		input l2_cache_pkg::strand_t strand, input l2_cache_pkg::way_t way,
		input l2_cache_pkg::line_addr_t addr, input l2_cache_pkg::byte_mask_t mask,
		input l2_cache_pkg::line_data_t data, input logic expect_write);
		logic exp_status;
		exp_status = op == l2_cache_pkg::pci_store_sync && expect_write;
		if (expect_write)
			model[addr] = merge_line(model[addr], data, mask);
		issue_and_check(unit, strand, op, way, addr, mask, data,
			l2_cache_pkg::cpi_store_ack, model[addr], exp_status);
	endtask

	task automatic test_store_then_load();
		l2_cache_pkg::line_addr_t addr;
		for (int i = 0; i < 2 ** l2_cache_pkg::line_addr_bits; i++)
		begin
			addr = l2_cache_pkg::line_addr_t'(i);
			do_store(l2_cache_pkg::pci_store, l2_cache_pkg::unit_t'(i),
				l2_cache_pkg::strand_t'(i >> 2), l2_cache_pkg::way_t'(i >> 4), addr, '1,
				random_line(), 1'b1);
		end
		for (int i = 0; i < 2 ** l2_cache_pkg::line_addr_bits; i++)
		begin
			addr = l2_cache_pkg::line_addr_t'(i);
			do_load(l2_cache_pkg::pci_load, l2_cache_pkg::unit_t'(i >> 1),
				l2_cache_pkg::strand_t'(i), l2_cache_pkg::way_t'(i >> 3), addr);
		end
	endtask

	task automatic test_partial_store();
		l2_cache_pkg::line_addr_t addr;
		for (int i = 0; i < 8; i++)
		begin
			addr = l2_cache_pkg::line_addr_t'($random(seed));
			do_store(l2_cache_pkg::pci_store, 2'd2, 2'd1, 2'd3, addr, random_mask(),
				random_line(), 1'b1);
			do_load(l2_cache_pkg::pci_load, 2'd2, 2'd1, 2'd3, addr);
		end
	endtask

	// Two tags share one set, so each load after the other's store must refill
	task automatic test_eviction();
		l2_cache_pkg::line_addr_t addr_a;
		l2_cache_pkg::line_addr_t addr_b;
		for (int b = 0; b < l2_cache_pkg::num_banks; b++)
		begin
			addr_a = {l2_cache_pkg::tag_t'(0), l2_cache_pkg::set_idx_t'(b),
				l2_cache_pkg::bank_idx_t'(b)};
			addr_b = {l2_cache_pkg::tag_t'(3), l2_cache_pkg::set_idx_t'(b),
				l2_cache_pkg::bank_idx_t'(b)};
			do_load(l2_cache_pkg::pci_load, 2'd0, 2'd0, 2'd1, addr_a);
			do_store(l2_cache_pkg::pci_store, 2'd0, 2'd1, 2'd1, addr_b, '1, random_line(), 1'b1);
			do_load(l2_cache_pkg::pci_load, 2'd0, 2'd0, 2'd2, addr_a);
			do_load(l2_cache_pkg::pci_load, 2'd0, 2'd1, 2'd2, addr_b);
		end
	endtask

	task automatic test_sync_success();
		l2_cache_pkg::line_addr_t addr;
		addr = 6'd5;
		do_load(l2_cache_pkg::pci_load_sync, 2'd1, 2'd2, 2'd0, addr);
		do_store(l2_cache_pkg::pci_store_sync, 2'd1, 2'd2, 2'd0, addr, random_mask(),
			random_line(), 1'b1);
		do_load(l2_cache_pkg::pci_load, 2'd1, 2'd2, 2'd0, addr);
		// Reservation is used up by the successful store-sync
		do_store(l2_cache_pkg::pci_store_sync, 2'd1, 2'd2, 2'd0, addr, '1, random_line(), 1'b0);
	endtask

	task automatic test_sync_failure();
		l2_cache_pkg::line_addr_t addr;
		addr = 6'd22;
		do_load(l2_cache_pkg::pci_load_sync, 2'd2, 2'd0, 2'd1, addr);
		do_store(l2_cache_pkg::pci_store, 2'd2, 2'd3, 2'd1, addr, '1, random_line(), 1'b1);
		do_store(l2_cache_pkg::pci_store_sync, 2'd2, 2'd0, 2'd1, addr, '1, random_line(), 1'b0);
		do_load(l2_cache_pkg::pci_load, 2'd2, 2'd0, 2'd1, addr);
	endtask

	// One request per bank, responses matched by unit and strand
	task automatic test_back_to_back();
		l2_cache_pkg::line_addr_t addr [l2_cache_pkg::num_banks];
		l2_cache_pkg::way_t exp_way [l2_cache_pkg::num_banks];
		l2_cache_pkg::line_data_t exp_data [l2_cache_pkg::num_banks];
		bit seen [l2_cache_pkg::num_banks];
		l2_cache_pkg::unit_t r_unit;
		l2_cache_pkg::strand_t r_strand;
		l2_cache_pkg::cpi_op_t r_op;
		l2_cache_pkg::way_t r_way;
		l2_cache_pkg::line_data_t r_data;
		logic r_status;
		int slot;
		for (int pass = 0; pass < 2; pass++)
		begin
			for (int b = 0; b < l2_cache_pkg::num_banks; b++)
			begin
				addr[b] = {l2_cache_pkg::tag_t'(b), l2_cache_pkg::set_idx_t'(3 - b),
					l2_cache_pkg::bank_idx_t'(b)};
				exp_way[b] = l2_cache_pkg::way_t'(b + pass);
				seen[b] = 1'b0;
				if (pass == 0)
					model[addr[b]] = random_line();
				exp_data[b] = model[addr[b]];
				send_request(l2_cache_pkg::unit_t'(b), l2_cache_pkg::strand_t'(3 - b),
					pass == 0 ? l2_cache_pkg::pci_store : l2_cache_pkg::pci_load,
					exp_way[b], addr[b], '1, exp_data[b]);
			end
			release_bus();
			for (int n = 0; n < l2_cache_pkg::num_banks; n++)
			begin
				wait_response(r_unit, r_strand, r_op, r_way, r_data, r_status);
				slot = -1;
				for (int b = 0; b < l2_cache_pkg::num_banks; b++)
				begin
					if (!seen[b] && int'(r_unit) == b && int'(r_strand) == 3 - b)
						slot = b;
				end
				if (slot < 0)
				begin
					protocol_errors++;
					$display("Response for unit %0d strand %0d matches no open request",
						r_unit, r_strand);
				end
				else
				begin
					seen[slot] = 1'b1;
					compare_op("cpi_op", r_op,
						pass == 0 ? l2_cache_pkg::cpi_store_ack : l2_cache_pkg::cpi_load_ack);
					compare_way("cpi_way", r_way, exp_way[slot]);
					compare_data("cpi_data", r_data, exp_data[slot]);
					compare_status("cpi_status", r_status, 1'b0);
				end
			end
		end
	endtask

	initial
	begin
		reset = 1'b1;
		pci_valid = 1'b0;
		pci_unit = '0;
		pci_strand = '0;
		pci_op = l2_cache_pkg::pci_load;
		pci_way = '0;
		pci_addr = '0;
		pci_mask = '0;
		pci_data = '0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		test_store_then_load();
		test_partial_store();
		test_eviction();
		test_sync_success();
		test_sync_failure();
		test_back_to_back();
		// Nothing more may come back once all requests are answered
		repeat (10) @(posedge clk);
		if (got_unit_q.size() != 0)
		begin
			protocol_errors++;
			$display("%0d CPI responses arrived without a request", got_unit_q.size());
		end
		finish_run();
	end

endmodule
